// File: list.f
+incdir+verification
rtl/rv_m_pkg.sv
rtl/rv_divu.sv
rtl/rv_ext_div.sv
rtl/rv_ext_mul.sv
rtl/rv_m_unit.sv
verification/rv_m_unit_tb.sv

// File: verification/rv_m_tests.svh
// Directed tests for rv_m_unit_tb, included inside the testbench module

// Compare one DUT output with its expected value
task automatic check_value(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
  assert (got === exp) else begin
    mismatch_count++;
    $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
  end
endtask

// One-cycle en, driven 1 ns after the rising edge
task automatic issue_request(m_op_e f, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
  @(posedge clk);
  #1;
  en  = 1'b1;
  op  = f;
  rs1 = a;
  rs2 = b;
  // Accepting edge
  @(posedge clk);
  #1;
  en = 1'b0;
endtask

// Waits for done, then watches quiet_cycles more for a stray pulse
task automatic wait_for_done(int quiet_cycles, output logic [XLEN-1:0] value);
  int cycles;
  int extra;
  bit seen;
  cycles = 0;
  extra  = 0;
  seen   = 1'b0;
  value  = '0;
  while (!seen && cycles < WAIT_LIMIT) begin
    if (done === 1'b1) begin
      seen  = 1'b1;
      value = result;
    end else begin
      @(posedge clk);
      #1;
      cycles++;
    end
  end
  assert (seen) else begin
    failure_count++;
    $display("Timeout at %0t: done did not pulse within %0d cycles", $time, WAIT_LIMIT);
  end
  if (seen) begin
    for (int i = 0; i < quiet_cycles; i++) begin
      @(posedge clk);
      #1;
      if (done !== 1'b0) extra++;
    end
    assert (extra == 0) else begin
      failure_count++;
      $display("Error at %0t: done pulsed %0d extra times for one request", $time, extra);
    end
    // Result must hold after done
    check_value("result (held)", result, value);
  end
endtask

// Request and compare against a literal value
task automatic run_and_expect(m_op_e f, logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                              logic [XLEN-1:0] exp);
  logic [XLEN-1:0] got;
  issue_request(f, a, b);
  wait_for_done(4, got);
  check_value($sformatf("result (%s)", f.name()), got, exp);
endtask

// Request and compare against the reference model
task automatic run_and_check(m_op_e f, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
  run_and_expect(f, a, b, expected_result(f, a, b));
endtask

// Reset values, then one case of each operation
task automatic test_reset_and_directed();
  check_value("busy", XLEN'(busy), '0);
  check_value("done", XLEN'(done), '0);
  check_value("result", result, '0);
  // 7 * -3
  run_and_check(MUL, 32'd7, 32'hFFFF_FFFD);
  run_and_check(MULH, 32'h1234_5678, 32'h8765_4321);
  run_and_check(MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
  run_and_check(MULHU, 32'hFFFF_FFFF, 32'h0000_0002);
  // -100 / 7 rounds toward zero
  run_and_check(DIV, 32'hFFFF_FF9C, 32'd7);
  run_and_check(DIVU, 32'd1000, 32'd33);
  run_and_check(REM, 32'hFFFF_FF9C, 32'd7);
  run_and_check(REMU, 32'hDEAD_BEEF, 32'd1234);
endtask

// 20 LFSR operand pairs for each operation
task automatic test_random_operands();
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  int              shift;
  for (int k = 0; k < 8; k++) begin
    for (int i = 0; i < 20; i++) begin
      a = random_word(32);
      b = random_word(32);
      // Make sure both signs show up in every group
      if (i == 0) a[31] = 1'b1;
      if (i == 2) b[31] = 1'b1;
      // Narrower divisors on odd cases give larger quotients, sign kept
      if (i % 2 == 1) begin
        shift = int'(random_word(5));
        b = $signed(b) >>> shift;
      end
      run_and_check(m_op_e'(k), a, b);
    end
  end
endtask

// Zero divisor, signed overflow and high words of extreme operands
task automatic test_edge_cases();
  run_and_expect(DIV, 32'h1234_5678, 32'h0, 32'hFFFF_FFFF);
  run_and_expect(DIVU, 32'h8000_0001, 32'h0, 32'hFFFF_FFFF);
  run_and_expect(REM, 32'h8000_0001, 32'h0, 32'h8000_0001);
  run_and_expect(REMU, 32'hCAFE_F00D, 32'h0, 32'hCAFE_F00D);
  // Signed overflow
  run_and_expect(DIV, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
  run_and_expect(REM, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
  // Most negative squared
  run_and_expect(MUL, 32'h8000_0000, 32'h8000_0000, 32'h0000_0000);
  run_and_expect(MULH, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
  run_and_expect(MULHSU, 32'h8000_0000, 32'h8000_0000, 32'hC000_0000);
  run_and_expect(MULHU, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
  // Most negative times all ones, three different high words
  run_and_expect(MULH, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
  run_and_expect(MULHSU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
  run_and_expect(MULHU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF);
endtask

// A second en during a division is dropped
task automatic test_back_pressure();
  logic [XLEN-1:0] got;
  issue_request(DIV, 32'hFFFF_F000, 32'd3);
  @(posedge clk);
  #1;
  check_value("busy", XLEN'(busy), XLEN'(1));
  en  = 1'b1;
  op  = MUL;
  rs1 = 32'd5;
  rs2 = 32'd6;
  @(posedge clk);
  #1;
  en = 1'b0;
  // Watch long enough for a second division to finish
  wait_for_done(WAIT_LIMIT, got);
  check_value("result (DIV)", got, expected_result(DIV, 32'hFFFF_F000, 32'd3));
endtask

// Inputs turn to garbage right after acceptance
task automatic request_with_garbage(m_op_e f, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
  logic [XLEN-1:0] got;
  issue_request(f, a, b);
  op  = m_op_e'(random_word(3));
  rs1 = random_word(32);
  rs2 = random_word(32);
  wait_for_done(4, got);
  check_value($sformatf("result (%s)", f.name()), got, expected_result(f, a, b));
endtask

task automatic test_operand_latching();
  request_with_garbage(DIVU, 32'hFEDC_BA98, 32'd17);
  request_with_garbage(REM, 32'h8765_4321, 32'hFFFF_FF10);
  request_with_garbage(MULHSU, 32'hF000_000F, 32'h9ABC_DEF0);
endtask

// File: verification/rv_m_unit_tb.sv
`timescale 1ns/10ps

// Testbench top for the M-extension execute unit
// Drives one request at a time through the en, busy and done handshake
module rv_m_unit_tb;

  import rv_m_pkg::*;

  // Longest wait for done, a full division plus handshake slack
  localparam int WAIT_LIMIT = DIV_CYCLES + 10;

  // DUT ports
  logic            clk;
  logic            rst_n;
  logic            en;
  m_op_e           op;
  logic [XLEN-1:0] rs1;
  logic [XLEN-1:0] rs2;
  logic            busy;
  logic            done;
  logic [XLEN-1:0] result;

  // Error counters
  int              mismatch_count;
  int              failure_count;

  // Random source state
  logic [31:0]     lfsr_q;

  rv_m_unit dut (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .op    (op),
    .rs1   (rs1),
    .rs2   (rs2),
    .busy  (busy),
    .done  (done),
    .result(result)
  );

  // 50 MHz clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // Collects the given number of LFSR bits, MSB first
  function automatic logic [31:0] random_word(int bits);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < bits; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  // Expected result straight from the RISC-V M-extension rules
  function automatic logic [XLEN-1:0] expected_result(m_op_e f, logic [XLEN-1:0] a,
                                                      logic [XLEN-1:0] b);
    longint      sa;
    longint      sb;
    longint      ua;
    longint      ub;
    logic [63:0] full;
    logic        overflow;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    // Zero extended magnitudes
    ua = longint'({32'h0, a});
    ub = longint'({32'h0, b});
    // Most negative over minus one
    overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
    case (f)
      MUL: begin
        full = sa * sb;
        return full[31:0];
      end
      MULH: begin
        full = sa * sb;
        return full[63:32];
      end
      MULHSU: begin
        full = sa * ub;
        return full[63:32];
      end
      MULHU: begin
        // Bit pattern mod 2^64 is right whatever the sign of longint
        full = ua * ub;
        return full[63:32];
      end
      DIV: begin
        if (b == '0) return '1;
        if (overflow) return a;
        full = sa / sb;
        return full[31:0];
      end
      DIVU: begin
        if (b == '0) return '1;
        full = ua / ub;
        return full[31:0];
      end
      REM: begin
        if (b == '0) return a;
        if (overflow) return '0;
        full = sa % sb;
        return full[31:0];
      end
      default: begin
        if (b == '0) return a;
        full = ua % ub;
        return full[31:0];
      end
    endcase
  endfunction

  `include "rv_m_tests.svh"

  // Main sequence
  initial begin
    mismatch_count = 0;
    failure_count  = 0;
    lfsr_q         = 32'd48420;
    rst_n          = 1'b0;
    en             = 1'b0;
    op             = MUL;
    rs1            = '0;
    rs2            = '0;
    // Reset held for 10 cycles
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset_and_directed();
    test_random_operands();
    test_edge_cases();
    test_back_pressure();
    test_operand_latching();

    $display("Error counts: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: rtl/rv_m_unit.sv
`timescale 1ns/10ps

// M-extension execute unit
// Accepts a one-cycle en when idle, latches the request, runs it on the
// multiply or divide unit and returns the result with a one-cycle done
module rv_m_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      en,
  input  rv_m_pkg::m_op_e           op,
  input  logic [rv_m_pkg::XLEN-1:0] rs1,
  input  logic [rv_m_pkg::XLEN-1:0] rs2,
  output logic                      busy,
  output logic                      done,
  output logic [rv_m_pkg::XLEN-1:0] result
);

  import rv_m_pkg::*;

  // Latched request
  m_op_e           op_q;
  logic [XLEN-1:0] rs1_q;
  logic [XLEN-1:0] rs2_q;

  // Handshake state
  logic            accept;
  logic            busy_q;
  logic            start_q;
  logic            done_q;
  logic [XLEN-1:0] result_q;

  // Per-unit start
  logic            mul_start;
  logic            div_start;

  // Unit returns
  logic            mul_valid;
  logic [XLEN-1:0] mul_result;
  logic            div_valid;
  logic [XLEN-1:0] div_result;
  logic            unit_valid;
  logic [XLEN-1:0] unit_result;

  // Requests while busy are dropped, that is the only back-pressure
  assign accept = en & ~busy_q;

  // Operands are captured so the core can move on after en
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q  <= op;
      rs1_q <= rs1;
      rs2_q <= rs2;
    end
  end

  // Bit 2 of the op code picks the divide group
  assign mul_start = start_q & ~op_q[2];
  assign div_start = start_q & op_q[2];

  rv_ext_mul u_mul (
    .clk   (clk),
    .rst_n (rst_n),
    .start (mul_start),
    .op    (op_q),
    .rs1   (rs1_q),
    .rs2   (rs2_q),
    .valid (mul_valid),
    .result(mul_result)
  );

  rv_ext_div u_div (
    .clk   (clk),
    .rst_n (rst_n),
    .start (div_start),
    .op    (op_q),
    .rs1   (rs1_q),
    .rs2   (rs2_q),
    .valid (div_valid),
    .result(div_result)
  );

  // Only one unit runs at a time
  assign unit_valid  = mul_valid | div_valid;
  assign unit_result = div_valid ? div_result : mul_result;

  // Handshake control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      // Start the selected unit on the edge after acceptance
      start_q <= accept;
      // Done follows the unit's valid by one edge
      done_q  <= unit_valid;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (unit_valid) begin
        // Busy drops as done rises, so a new request can land in the done cycle
        busy_q <= 1'b0;
      end
    end
  end

  // Result holds until the next completion
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_q <= '0;
    end else if (unit_valid) begin
      result_q <= unit_result;
    end
  end

  assign busy   = busy_q;
  assign done   = done_q;
  assign result = result_q;

endmodule

// File: rtl/rv_ext_mul.sv
`timescale 1ns/10ps

// MUL, MULH, MULHSU and MULHU
// Both operands widen to 33 bits so one signed multiplier covers all four
// Result is ready the cycle after start
module rv_ext_mul (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  rv_m_pkg::m_op_e           op,
  input  logic [rv_m_pkg::XLEN-1:0] rs1,
  input  logic [rv_m_pkg::XLEN-1:0] rs2,
  output logic                      valid,
  output logic [rv_m_pkg::XLEN-1:0] result
);

  import rv_m_pkg::*;

  // Extension mode per operand
  logic                   rs1_signed;
  logic                   rs2_signed;

  // Extended operands
  logic signed [XLEN:0]   a_ext;
  logic signed [XLEN:0]   b_ext;

  // Registered full product
  logic signed [2*XLEN+1:0] prod_q;
  // Word select captured with the product
  logic                   low_q;
  logic                   valid_q;

  // rs1 is signed for everything but MULHU
  assign rs1_signed = (op != MULHU);
  // rs2 is unsigned for MULHSU and MULHU
  // MUL only uses the low word, which is the same either way
  assign rs2_signed = (op == MUL) || (op == MULH);

  // Sign or zero extension into the spare top bit
  assign a_ext = {rs1_signed & rs1[XLEN-1], rs1};
  assign b_ext = {rs2_signed & rs2[XLEN-1], rs2};

  // Product only updates on a request
  always_ff @(posedge clk) begin
    if (start) begin
      prod_q <= a_ext * b_ext;
      low_q  <= (op == MUL);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      // One cycle of latency, never stalls
      valid_q <= start;
    end
  end

  assign valid = valid_q;

  // Low word for MUL, high word for the rest
  // Bits above 2*XLEN are only sign extension of the product
  assign result = low_q ? prod_q[XLEN-1:0] : prod_q[2*XLEN-1:XLEN];

endmodule

// File: rtl/rv_ext_div.sv
`timescale 1ns/10ps

// DIV, DIVU, REM and REMU around the unsigned divider
// Operands are held stable by the caller until valid
module rv_ext_div (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  rv_m_pkg::m_op_e           op,
  input  logic [rv_m_pkg::XLEN-1:0] rs1,
  input  logic [rv_m_pkg::XLEN-1:0] rs2,
  output logic                      valid,
  output logic [rv_m_pkg::XLEN-1:0] result
);

  import rv_m_pkg::*;

  // Operation decode
  logic            is_signed;
  logic            is_rem;
  logic            rs1_neg;
  logic            rs2_neg;

  // Divider interface
  logic [XLEN-1:0] dividend_abs;
  logic [XLEN-1:0] divisor_abs;
  logic            div_valid;
  logic            div_zero;
  logic [XLEN-1:0] quotient;
  logic [XLEN-1:0] remainder;

  // Sign corrected results
  logic [XLEN-1:0] quo_signed;
  logic [XLEN-1:0] rem_signed;

  // Start delayed by one cycle for the zero divisor answer
  logic            start_q;

  // DIV and REM have bit 0 clear
  assign is_signed = ~op[0];
  // REM and REMU have bit 1 set
  assign is_rem    = op[1];

  assign rs1_neg = is_signed & rs1[XLEN-1];
  assign rs2_neg = is_signed & rs2[XLEN-1];

  // Magnitudes for the unsigned core
  // The most negative value maps onto itself, which is its correct magnitude
  assign dividend_abs = rs1_neg ? -rs1 : rs1;
  assign divisor_abs  = rs2_neg ? -rs2 : rs2;

  rv_divu #(
    .WIDTH(XLEN)
  ) u_divu (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .dividend (dividend_abs),
    .divisor  (divisor_abs),
    .busy     (),
    .valid    (div_valid),
    .div_zero (div_zero),
    .quotient (quotient),
    .remainder(remainder)
  );

  // Quotient is negative when the operand signs differ
  assign quo_signed = (rs1_neg ^ rs2_neg) ? -quotient : quotient;
  // Remainder takes the sign of the dividend
  assign rem_signed = rs1_neg ? -remainder : remainder;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start;
    end
  end

  // Zero divisor answers the cycle after start
  assign valid = div_valid | (start_q & div_zero);

  // Zero divisor gives all ones or the dividend as RISC-V requires
  always_comb begin
    if (div_zero) begin
      result = is_rem ? rs1 : '1;
    end else begin
      result = is_rem ? rem_signed : quo_signed;
    end
  end

endmodule

// File: rtl/rv_divu.sv
`timescale 1ns/10ps

// Unsigned restoring divider
// Loads on start, then produces one quotient bit per cycle for WIDTH cycles
// A zero divisor is flagged at start and never enters the busy state
module rv_divu #(
  parameter int WIDTH = rv_m_pkg::XLEN
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  logic [WIDTH-1:0] dividend,
  input  logic [WIDTH-1:0] divisor,
  output logic             busy,
  output logic             valid,
  output logic             div_zero,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder
);

  // Bit counter width, enough to count 0 .. WIDTH-1
  localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

  // Control state
  logic             busy_q;
  logic             valid_q;
  logic             zero_q;
  logic [CNT_W-1:0] count_q;
  logic             last_step;

  // Partial remainder
  logic [WIDTH-1:0] rem_q;
  // Dividend shifts out of the top while quotient bits shift in at the bottom
  logic [WIDTH-1:0] quo_q;
  // Divisor held for the whole iteration
  logic [WIDTH-1:0] dvs_q;

  // One restoring step
  logic [WIDTH:0]   partial;
  logic [WIDTH+1:0] diff;
  logic             fits;

  // Shift the next dividend bit into the partial remainder
  assign partial = {rem_q, quo_q[WIDTH-1]};

  // Trial subtraction with a spare sign bit
  assign diff = {1'b0, partial} - {2'b00, dvs_q};

  // Non-negative difference means the divisor fits, quotient bit is one
  assign fits = ~diff[WIDTH+1];

  // Final iteration of the current division
  assign last_step = (count_q == CNT_W'(WIDTH - 1));

  // Control: busy window, bit counter, valid pulse, zero flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      zero_q  <= 1'b0;
      count_q <= '0;
    end else begin
      // Valid is a single-cycle pulse
      valid_q <= 1'b0;
      if (start) begin
        // Zero divisor skips the iteration, the wrapper answers directly
        zero_q  <= (divisor == '0);
        busy_q  <= (divisor != '0);
        count_q <= '0;
      end else if (busy_q) begin
        count_q <= count_q + CNT_W'(1);
        if (last_step) begin
          busy_q  <= 1'b0;
          valid_q <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (start) begin
      rem_q <= '0;
      quo_q <= dividend;
      dvs_q <= divisor;
    end else if (busy_q) begin
      // Restore by keeping the unsubtracted value when the divisor does not fit
      rem_q <= fits ? diff[WIDTH-1:0] : partial[WIDTH-1:0];
      quo_q <= {quo_q[WIDTH-2:0], fits};
    end
  end

  assign busy      = busy_q;
  assign valid     = valid_q;
  assign div_zero  = zero_q;
  assign quotient  = quo_q;
  assign remainder = rem_q;

endmodule

// File: rtl/rv_m_pkg.sv
// Shared definitions for the RV32 M-extension execute unit
package rv_m_pkg;

  // Operand and result width
  localparam int XLEN = 32;

  // Iteration cycles of the restoring divider
  // One quotient bit per cycle, so one cycle per operand bit
  localparam int DIV_CYCLES = XLEN;

  // M-extension operation code
  // Values match the funct3 field of the OP opcode with funct7 = 0000001
  //   bit 2 set selects the divide group
  //   in the divide group bit 0 set means unsigned
  //   in the divide group bit 1 set means remainder
  typedef enum logic [2:0] {
    // Low word of rs1 * rs2
    MUL    = 3'd0,
    // High word, both operands signed
    MULH   = 3'd1,
    // High word, rs1 signed and rs2 unsigned
    MULHSU = 3'd2,
    // High word, both operands unsigned
    MULHU  = 3'd3,
    // Signed quotient
    DIV    = 3'd4,
    // Unsigned quotient
    DIVU   = 3'd5,
    // Signed remainder
    REM    = 3'd6,
    // Unsigned remainder
    REMU   = 3'd7
  } m_op_e;

  // Division corner cases handled by the divide unit
  //   x / 0 gives all ones as quotient and x as remainder
  //   most negative / -1 gives the dividend as quotient and zero as remainder
  // Both fall out of the sign correction except the zero divisor,
  // which bypasses the iteration entirely

endpackage
